/* dv/tb_sched_rename.sv */
// ==============================
// testbench for the rename front end
// random stimulus, reference model,
// assertion checks and watchdog
// ==============================

`timescale 1ns/10ps

module tb_sched_rename;

  localparam int PHY_REG_NUM = 64;
  localparam int PREG_W      = $clog2(PHY_REG_NUM);
  localparam int CLK_PERIOD  = 8;
  localparam int N_RANDOM    = 520;
  localparam int N_BURST     = 48;
  localparam int N_TAIL      = 32;
  localparam int N_INSTR     = N_RANDOM + N_BURST + N_TAIL;

  typedef struct packed {
    logic [31:0]       pc;
    logic              excp_valid;
    logic [5:0]        ecode;
    logic              dest_valid;
    logic [PREG_W-1:0] psrc0;
    logic [PREG_W-1:0] psrc1;
    logic [PREG_W-1:0] pdest;
    logic [PREG_W-1:0] ppdst;
  } rec_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   in_valid_i;
  logic                   in_ready_o;
  logic [31:0]            in_pc_i;
  sched_pkg::instr_type_e in_instr_type_i;
  sched_pkg::misc_op_e    in_misc_op_i;
  logic                   in_invalid_i;
  logic                   in_fetch_excp_valid_i;
  sched_pkg::ecode_e      in_fetch_ecode_i;
  sched_pkg::arch_reg_t   in_arch_src0_i;
  sched_pkg::arch_reg_t   in_arch_src1_i;
  sched_pkg::arch_reg_t   in_arch_dest_i;
  logic                   csr_has_int_i;
  logic [1:0]             csr_plv_i;
  logic                   free_valid_i;
  logic [PREG_W-1:0]      free_preg_i;
  logic                   out_valid_o;
  logic                   out_ready_i;
  logic [31:0]            out_pc_o;
  logic                   out_excp_valid_o;
  sched_pkg::ecode_e      out_ecode_o;
  logic                   out_dest_valid_o;
  logic [PREG_W-1:0]      out_psrc0_o;
  logic [PREG_W-1:0]      out_psrc1_o;
  logic [PREG_W-1:0]      out_pdest_o;
  logic [PREG_W-1:0]      out_ppdst_o;

  // reference model state
  rec_t              exp_q[$];
  logic [PREG_W-1:0] free_q[$];
  logic [PREG_W-1:0] model_rat [sched_pkg::ARCH_REG_NUM];
  logic [PREG_W-1:0] rel_preg_q[$];
  int                rel_due_q[$];
  rec_t              exp_rec;
  logic              exp_present;
  logic              exp_ready;
  logic              in_fire_nx;
  bit                hold_retire;
  bit                burst_mode;
  int                errors;
  int                n_in;
  int                n_out;
  int                stall_cycles;
  int                cycle;
  logic [31:0]       pc_next;

  sched_rename_top #(.PHY_REG_NUM(PHY_REG_NUM)) UUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==============================
  // reference model
  // ==============================
  // INT > fetch > INE > IPE > SYS > BRK
  function automatic void predict_excp(input logic has_int, input logic fetch_v,
                                       input logic [5:0] fetch_code, input logic inv,
                                       input logic [2:0] ty, input logic [1:0] mop,
                                       input logic [1:0] plv, output logic v,
                                       output logic [5:0] code);
    v    = 1'b1;
    code = 6'h00;
    if (has_int) code = sched_pkg::INT;
    else if (fetch_v) code = fetch_code;
    else if (inv) code = sched_pkg::INE;
    else if (ty == sched_pkg::PRIV && plv == sched_pkg::PLV_USER) code = sched_pkg::IPE;
    else if (ty == sched_pkg::MISC && mop == sched_pkg::SYSCALL) code = sched_pkg::SYS;
    else if (ty == sched_pkg::MISC && mop == sched_pkg::BREAK) code = sched_pkg::BRK;
    else v = 1'b0;
  endfunction

  task automatic reset_model();
    exp_q.delete();
    free_q.delete();
    for (int i = 0; i < sched_pkg::ARCH_REG_NUM; i++) model_rat[i] = PREG_W'(i);
    for (int i = sched_pkg::ARCH_REG_NUM; i < PHY_REG_NUM; i++) free_q.push_back(PREG_W'(i));
    exp_rec     = '0;
    exp_present = 1'b0;
    exp_ready   = 1'b1;
    in_fire_nx  = 1'b0;
  endtask

  // runs at the falling edge and predicts the next rising edge
  task automatic step_model();
    logic       v;
    logic [5:0] code;
    logic       needs;
    rec_t       r;
    predict_excp(csr_has_int_i, in_fetch_excp_valid_i, in_fetch_ecode_i, in_invalid_i,
                 in_instr_type_i, in_misc_op_i, csr_plv_i, v, code);
    needs       = (in_arch_dest_i != '0) && !v;
    exp_ready   = (exp_q.size() == 0 || out_ready_i) && (!needs || free_q.size() != 0);
    exp_present = 1'b0;
    in_fire_nx  = 1'b0;
    if (hold_retire && in_valid_i && !exp_ready) stall_cycles++;
    // record leaving the output register
    if (exp_q.size() != 0 && out_ready_i) begin
      exp_rec     = exp_q.pop_front();
      exp_present = 1'b1;
      n_out++;
      if (exp_rec.dest_valid) begin
        rel_preg_q.push_back(exp_rec.ppdst);
        rel_due_q.push_back(cycle + 1 + $urandom_range(0, 6));
      end
    end
    if (in_valid_i && exp_ready) begin
      r.pc         = in_pc_i;
      r.excp_valid = v;
      r.ecode      = code;
      r.dest_valid = needs;
      r.psrc0      = (in_arch_src0_i == '0) ? '0 : model_rat[in_arch_src0_i];
      r.psrc1      = (in_arch_src1_i == '0) ? '0 : model_rat[in_arch_src1_i];
      r.pdest      = needs ? free_q[0] : '0;
      r.ppdst      = needs ? model_rat[in_arch_dest_i] : '0;
      if (needs) model_rat[in_arch_dest_i] = free_q.pop_front();
      exp_q.push_back(r);
      in_fire_nx = 1'b1;
      n_in++;
    end
    // release lands behind any pop on the same edge
    if (free_valid_i) free_q.push_back(free_preg_i);
  endtask

  always @(negedge clk) begin
    if (!rst_n) reset_model();
    else step_model();
  end

  // ==============================
  // output sink and retirement
  // ==============================
  always @(posedge clk) begin
    cycle       <= cycle + 1;
    out_ready_i <= burst_mode || ($urandom_range(0, 9) < 7);
    if (!hold_retire && rel_due_q.size() != 0 && rel_due_q[0] <= cycle) begin
      free_valid_i <= 1'b1;
      free_preg_i  <= rel_preg_q.pop_front();
      void'(rel_due_q.pop_front());
    end else begin
      free_valid_i <= 1'b0;
    end
  end

  // ==============================
  // checks
  // ==============================
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    errors++;
    $display("ERROR: %s got %h expected %h at %0t", name, got, expected, $time);
  endtask

  a_reset: assert property (@(posedge clk) !rst_n ##1 !rst_n |-> !out_valid_o && in_ready_o)
    else begin
      errors++;
      $display("output valid or input not ready while in reset");
    end
  a_ready: assert property (@(posedge clk) disable iff (!rst_n) in_ready_o == exp_ready)
    else report_mismatch("in_ready_o", $sampled(in_ready_o), exp_ready);
  a_transfer: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid_o && out_ready_i) == exp_present)
    else begin
      errors++;
      $display("output transfer does not line up with the expected record stream");
    end
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o &&
      $stable({out_pc_o, out_excp_valid_o, out_ecode_o, out_dest_valid_o,
               out_psrc0_o, out_psrc1_o, out_pdest_o, out_ppdst_o}))
    else begin
      errors++;
      $display("held record changed or vanished under back-pressure");
    end

  a_pc: assert property (@(posedge clk) disable iff (!rst_n)
    exp_present |-> out_pc_o == exp_rec.pc)
    else report_mismatch("out_pc_o", $sampled(out_pc_o), exp_rec.pc);
  a_excp: assert property (@(posedge clk) disable iff (!rst_n)
    exp_present |-> out_excp_valid_o == exp_rec.excp_valid)
    else report_mismatch("out_excp_valid_o", $sampled(out_excp_valid_o), exp_rec.excp_valid);
  a_ecode: assert property (@(posedge clk) disable iff (!rst_n)
    exp_present |-> out_ecode_o == exp_rec.ecode)
    else report_mismatch("out_ecode_o", $sampled(out_ecode_o), exp_rec.ecode);
  a_dest_valid: assert property (@(posedge clk) disable iff (!rst_n)
    exp_present |-> out_dest_valid_o == exp_rec.dest_valid)
    else report_mismatch("out_dest_valid_o", $sampled(out_dest_valid_o), exp_rec.dest_valid);
  a_psrc0: assert property (@(posedge clk) disable iff (!rst_n)
    exp_present |-> out_psrc0_o == exp_rec.psrc0)
    else report_mismatch("out_psrc0_o", $sampled(out_psrc0_o), exp_rec.psrc0);
  a_psrc1: assert property (@(posedge clk) disable iff (!rst_n)
    exp_present |-> out_psrc1_o == exp_rec.psrc1)
    else report_mismatch("out_psrc1_o", $sampled(out_psrc1_o), exp_rec.psrc1);
  a_pdest: assert property (@(posedge clk) disable iff (!rst_n)
    exp_present |-> out_pdest_o == exp_rec.pdest)
    else report_mismatch("out_pdest_o", $sampled(out_pdest_o), exp_rec.pdest);
  a_ppdst: assert property (@(posedge clk) disable iff (!rst_n)
    exp_present |-> out_ppdst_o == exp_rec.ppdst)
    else report_mismatch("out_ppdst_o", $sampled(out_ppdst_o), exp_rec.ppdst);

  // ==============================
  // stimulus
  // ==============================
  // clean means no exception source and a nonzero destination
  task automatic send_instr(input bit clean);
    in_valid_i            <= 1'b1;
    in_pc_i               <= pc_next;
    in_instr_type_i       <= clean ? sched_pkg::ALU :
                             sched_pkg::instr_type_e'($urandom_range(0, 5));
    in_misc_op_i          <= sched_pkg::misc_op_e'($urandom_range(0, 2));
    in_invalid_i          <= !clean && ($urandom_range(0, 11) == 0);
    in_fetch_excp_valid_i <= !clean && ($urandom_range(0, 15) == 0);
    in_fetch_ecode_i      <= sched_pkg::ecode_e'($urandom_range(0, 63));
    csr_has_int_i         <= !clean && ($urandom_range(0, 15) == 0);
    csr_plv_i             <= $urandom_range(0, 3);
    // small register range keeps dependencies dense
    in_arch_src0_i        <= $urandom_range(0, 7);
    in_arch_src1_i        <= $urandom_range(0, 7);
    in_arch_dest_i        <= clean ? $urandom_range(1, 7) : $urandom_range(0, 7);
    pc_next = pc_next + 32'd4;
    @(posedge clk);
    while (!in_fire_nx) @(posedge clk);
  endtask

  task automatic run_random(input int n);
    for (int i = 0; i < n; i++) begin
      send_instr(1'b0);
      if ($urandom_range(0, 7) == 0) begin
        in_valid_i <= 1'b0;
        repeat ($urandom_range(1, 3)) @(posedge clk);
      end
    end
  endtask

  initial begin
    void'($urandom(32'he35fc350));
    rst_n                 = 1'b0;
    in_valid_i            = 1'b0;
    in_pc_i               = '0;
    in_instr_type_i       = sched_pkg::ALU;
    in_misc_op_i          = sched_pkg::NONE;
    in_invalid_i          = 1'b0;
    in_fetch_excp_valid_i = 1'b0;
    in_fetch_ecode_i      = sched_pkg::INT;
    in_arch_src0_i        = '0;
    in_arch_src1_i        = '0;
    in_arch_dest_i        = '0;
    csr_has_int_i         = 1'b0;
    csr_plv_i             = 2'd0;
    free_valid_i          = 1'b0;
    free_preg_i           = '0;
    out_ready_i           = 1'b1;
    pc_next               = 32'h1c00_0000;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    run_random(N_RANDOM);
    // exhaust the free list with retirement held off
    burst_mode  <= 1'b1;
    hold_retire <= 1'b1;
    fork
      for (int k = 0; k < N_BURST; k++) send_instr(1'b1);
      begin
        wait (stall_cycles >= 12);
        hold_retire <= 1'b0;
      end
    join
    burst_mode <= 1'b0;
    run_random(N_TAIL);
    in_valid_i <= 1'b0;
    repeat (40) @(posedge clk);
    if (exp_q.size() != 0 || out_valid_o || n_out != n_in) begin
      errors++;
      $display("records still pending after drain, %0d in and %0d out", n_in, n_out);
    end
    $display("errors %0d, instructions in %0d, records out %0d", errors, n_in, n_out);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog allows 20 cycles per instruction
  initial begin
    #(20 * N_INSTR * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, errors %0d", 20 * N_INSTR, errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* sim.f */
verilog/sched_pkg.sv
verilog/rename_if.sv
verilog/excp_check.sv
verilog/rename_unit.sv
verilog/dispatch_stage.sv
verilog/sched_rename_top.sv
dv/tb_sched_rename.sv

/* verilog/dispatch_stage.sv */
// ==============================
// input/output handshake and the
// registered dispatch record
// ==============================

`timescale 1ns/10ps

module dispatch_stage #(
  parameter  int PHY_REG_NUM = 64,
  localparam int PREG_W      = $clog2(PHY_REG_NUM)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // instruction in
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [31:0]          in_pc_i,
  input  sched_pkg::arch_reg_t in_arch_src0_i,
  input  sched_pkg::arch_reg_t in_arch_src1_i,
  input  sched_pkg::arch_reg_t in_arch_dest_i,
  // exception result
  input  logic                 excp_valid_i,
  input  sched_pkg::ecode_e    excp_code_i,
  // rename unit
  rename_if.ctrl               ren,
  // dispatch record out
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [31:0]          out_pc_o,
  output logic                 out_excp_valid_o,
  output sched_pkg::ecode_e    out_ecode_o,
  output logic                 out_dest_valid_o,
  output logic [PREG_W-1:0]    out_psrc0_o,
  output logic [PREG_W-1:0]    out_psrc1_o,
  output logic [PREG_W-1:0]    out_pdest_o,
  output logic [PREG_W-1:0]    out_ppdst_o
);

  logic out_free;
  logic needs_alloc;
  logic in_fire;

  // ==============================
  // handshake and allocation
  // ==============================
  assign out_free    = !out_valid_o || out_ready_i;
  // faulting instructions and r0 writes take no register
  assign needs_alloc = (in_arch_dest_i != '0) && !excp_valid_i;
  assign in_ready_o  = out_free && (!needs_alloc || ren.free_avail);
  assign in_fire     = in_valid_i && in_ready_o;

  assign ren.alloc_en  = in_fire && needs_alloc;
  assign ren.arch_src0 = in_arch_src0_i;
  assign ren.arch_src1 = in_arch_src1_i;
  assign ren.arch_dest = in_arch_dest_i;

  // ==============================
  // output record
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
    end else if (in_fire) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_pc_o         <= in_pc_i;
      out_excp_valid_o <= excp_valid_i;
      out_ecode_o      <= excp_code_i;
      out_dest_valid_o <= ren.alloc_en;
      out_psrc0_o      <= ren.psrc0;
      out_psrc1_o      <= ren.psrc1;
      out_pdest_o      <= ren.alloc_en ? ren.pdest : '0;
      out_ppdst_o      <= ren.alloc_en ? ren.ppdst : '0;
    end
  end

  // held record stays put until taken
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o &&
      $stable({out_pc_o, out_excp_valid_o, out_ecode_o, out_dest_valid_o,
               out_psrc0_o, out_psrc1_o, out_pdest_o, out_ppdst_o}))
    else $error("dispatch_stage: record changed under back-pressure");

endmodule

/* verilog/excp_check.sv */
// ==============================
// priority exception classifier for
// the incoming instruction
// ==============================

`timescale 1ns/10ps

module excp_check (
  input  sched_pkg::instr_type_e instr_type_i,
  input  sched_pkg::misc_op_e    misc_op_i,
  input  logic                   invalid_i,
  input  logic                   fetch_excp_valid_i,
  input  sched_pkg::ecode_e      fetch_ecode_i,
  input  logic                   csr_has_int_i,
  input  logic [1:0]             csr_plv_i,
  output logic                   excp_valid_o,
  output sched_pkg::ecode_e      excp_code_o
);

  logic priv_fault;
  logic syscall_instr;
  logic break_instr;

  // privileged op attempted from user mode
  assign priv_fault    = (instr_type_i == sched_pkg::PRIV) &&
                         (csr_plv_i == sched_pkg::PLV_USER);
  assign syscall_instr = (instr_type_i == sched_pkg::MISC) &&
                         (misc_op_i == sched_pkg::SYSCALL);
  assign break_instr   = (instr_type_i == sched_pkg::MISC) &&
                         (misc_op_i == sched_pkg::BREAK);

  // any pending source raises the exception
  assign excp_valid_o = csr_has_int_i || fetch_excp_valid_i || invalid_i ||
                        priv_fault || syscall_instr || break_instr;

  // INT > fetch > INE > IPE > SYS > BRK
  always_comb begin
    excp_code_o = sched_pkg::ecode_e'(6'h00);
    if (csr_has_int_i) begin
      excp_code_o = sched_pkg::INT;
    end else if (fetch_excp_valid_i) begin
      excp_code_o = fetch_ecode_i;
    end else if (invalid_i) begin
      excp_code_o = sched_pkg::INE;
    end else if (priv_fault) begin
      excp_code_o = sched_pkg::IPE;
    end else if (syscall_instr) begin
      excp_code_o = sched_pkg::SYS;
    end else if (break_instr) begin
      excp_code_o = sched_pkg::BRK;
    end
  end

  // a clean instruction carries a zero code downstream
  a_code_zero: assert final (excp_valid_o || excp_code_o == sched_pkg::ecode_e'(6'h00))
    else $error("excp_check: nonzero ecode %0h without exception", excp_code_o);

endmodule

/* verilog/rename_if.sv */
// ==============================
// interface between the dispatch stage
// and the rename unit
// ==============================

`timescale 1ns/10ps

interface rename_if #(
  parameter int PHY_REG_NUM = 64
);

  localparam int PREG_W = $clog2(PHY_REG_NUM);

  // request side
  logic                 alloc_en;
  sched_pkg::arch_reg_t arch_src0;
  sched_pkg::arch_reg_t arch_src1;
  sched_pkg::arch_reg_t arch_dest;

  // lookup results, all combinational
  logic [PREG_W-1:0] psrc0;
  logic [PREG_W-1:0] psrc1;
  logic [PREG_W-1:0] pdest;
  logic [PREG_W-1:0] ppdst;
  logic              free_avail;

  modport ctrl (
    output alloc_en, arch_src0, arch_src1, arch_dest,
    input  psrc0, psrc1, pdest, ppdst, free_avail
  );

  modport rename (
    input  alloc_en, arch_src0, arch_src1, arch_dest,
    output psrc0, psrc1, pdest, ppdst, free_avail
  );

endinterface

/* verilog/rename_unit.sv */
// ==============================
// register alias table plus a circular
// free list of physical registers
// ==============================

`timescale 1ns/10ps

module rename_unit #(
  parameter  int PHY_REG_NUM = 64,
  localparam int PREG_W      = $clog2(PHY_REG_NUM)
) (
  input  logic              clk,
  input  logic              rst_n,
  rename_if.rename          ren,
  input  logic              free_valid_i,
  input  logic [PREG_W-1:0] free_preg_i
);

  localparam int CNT_W     = PREG_W + 1;
  localparam int INIT_FREE = PHY_REG_NUM - sched_pkg::ARCH_REG_NUM;

  // needs room for every register beyond the architectural set
  if (PHY_REG_NUM <= sched_pkg::ARCH_REG_NUM ||
      (PHY_REG_NUM & (PHY_REG_NUM - 1)) != 0) begin : g_bad_cfg
    $error("rename_unit: PHY_REG_NUM must be a power of two above 32");
  end

  logic [PREG_W-1:0] rat_q [sched_pkg::ARCH_REG_NUM];
  logic [PREG_W-1:0] fl_q  [PHY_REG_NUM];
  logic [PREG_W-1:0] head_q;
  logic [PREG_W-1:0] tail_q;
  logic [CNT_W-1:0]  count_q;
  logic              fl_full;

  // ==============================
  // table lookups
  // ==============================
  // r0 is hardwired to p0
  assign ren.psrc0 = (ren.arch_src0 == '0) ? '0 : rat_q[ren.arch_src0];
  assign ren.psrc1 = (ren.arch_src1 == '0) ? '0 : rat_q[ren.arch_src1];
  assign ren.ppdst = (ren.arch_dest == '0) ? '0 : rat_q[ren.arch_dest];

  // identity mapping out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < sched_pkg::ARCH_REG_NUM; i++) begin
        rat_q[i] <= PREG_W'(i);
      end
    end else if (ren.alloc_en) begin
      rat_q[ren.arch_dest] <= ren.pdest;
    end
  end

  // ==============================
  // free list
  // ==============================
  assign ren.pdest      = fl_q[head_q];
  assign ren.free_avail = (count_q != '0);
  assign fl_full        = (count_q == CNT_W'(PHY_REG_NUM));

  // starts holding p32 upward
  // slots past the count are don't-care
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PHY_REG_NUM; i++) begin
        fl_q[i] <= PREG_W'(i + sched_pkg::ARCH_REG_NUM);
      end
    end else if (free_valid_i) begin
      fl_q[tail_q] <= free_preg_i;
    end
  end

  // pop and push may share a cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= PREG_W'(INIT_FREE);
      count_q <= CNT_W'(INIT_FREE);
    end else begin
      if (ren.alloc_en) begin
        head_q <= head_q + 1'b1;
      end
      if (free_valid_i) begin
        tail_q <= tail_q + 1'b1;
      end
      case ({free_valid_i, ren.alloc_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ==============================
  // checks
  // ==============================
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    ren.alloc_en |-> ren.free_avail)
    else $error("rename_unit: allocation from an empty free list");

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    free_valid_i |-> !fl_full)
    else $error("rename_unit: release into a full free list");

  a_no_alloc_r0: assert property (@(posedge clk) disable iff (!rst_n)
    ren.alloc_en |-> ren.arch_dest != '0)
    else $error("rename_unit: allocation requested for r0");

endmodule

/* verilog/sched_pkg.sv */
// ==============================
// shared widths, instruction classes and
// exception codes for the rename front end
// ==============================

package sched_pkg;

  // architectural register file
  localparam int ARCH_REG_NUM = 32;

  typedef logic [4:0] arch_reg_t;

  // ==============================
  // instruction classes
  // ==============================
  typedef enum logic [2:0] {
    ALU  = 3'd0,
    MDU  = 3'd1,
    MEM  = 3'd2,
    MISC = 3'd3,
    BR   = 3'd4,
    PRIV = 3'd5
  } instr_type_e;

  // sub-op of a MISC instruction
  typedef enum logic [1:0] {
    NONE    = 2'd0,
    SYSCALL = 2'd1,
    BREAK   = 2'd2
  } misc_op_e;

  // ==============================
  // exception codes
  // ==============================
  typedef enum logic [5:0] {
    INT = 6'h00,
    SYS = 6'h0B,
    BRK = 6'h0C,
    INE = 6'h0D,
    IPE = 6'h0E
  } ecode_e;

  // lowest privilege level
  localparam logic [1:0] PLV_USER = 2'd3;

endpackage

/* verilog/sched_rename_top.sv */
// ==============================
// rename and exception front end,
// one instruction per cycle
// ==============================

`timescale 1ns/10ps

module sched_rename_top #(
  parameter  int PHY_REG_NUM = 64,
  localparam int PREG_W      = $clog2(PHY_REG_NUM)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // instruction in
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  logic [31:0]            in_pc_i,
  input  sched_pkg::instr_type_e in_instr_type_i,
  input  sched_pkg::misc_op_e    in_misc_op_i,
  input  logic                   in_invalid_i,
  input  logic                   in_fetch_excp_valid_i,
  input  sched_pkg::ecode_e      in_fetch_ecode_i,
  input  sched_pkg::arch_reg_t   in_arch_src0_i,
  input  sched_pkg::arch_reg_t   in_arch_src1_i,
  input  sched_pkg::arch_reg_t   in_arch_dest_i,
  // csr state
  input  logic                   csr_has_int_i,
  input  logic [1:0]             csr_plv_i,
  // register release from retire
  input  logic                   free_valid_i,
  input  logic [PREG_W-1:0]      free_preg_i,
  // dispatch record out
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic [31:0]            out_pc_o,
  output logic                   out_excp_valid_o,
  output sched_pkg::ecode_e      out_ecode_o,
  output logic                   out_dest_valid_o,
  output logic [PREG_W-1:0]      out_psrc0_o,
  output logic [PREG_W-1:0]      out_psrc1_o,
  output logic [PREG_W-1:0]      out_pdest_o,
  output logic [PREG_W-1:0]      out_ppdst_o
);

  logic              excp_valid;
  sched_pkg::ecode_e excp_code;

  rename_if #(.PHY_REG_NUM(PHY_REG_NUM)) ren_if ();

  excp_check u_excp_check (
    .instr_type_i       (in_instr_type_i),
    .misc_op_i          (in_misc_op_i),
    .invalid_i          (in_invalid_i),
    .fetch_excp_valid_i (in_fetch_excp_valid_i),
    .fetch_ecode_i      (in_fetch_ecode_i),
    .csr_has_int_i      (csr_has_int_i),
    .csr_plv_i          (csr_plv_i),
    .excp_valid_o       (excp_valid),
    .excp_code_o        (excp_code)
  );

  rename_unit #(.PHY_REG_NUM(PHY_REG_NUM)) u_rename_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .ren          (ren_if.rename),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i)
  );

  dispatch_stage #(.PHY_REG_NUM(PHY_REG_NUM)) u_dispatch_stage (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .in_pc_i          (in_pc_i),
    .in_arch_src0_i   (in_arch_src0_i),
    .in_arch_src1_i   (in_arch_src1_i),
    .in_arch_dest_i   (in_arch_dest_i),
    .excp_valid_i     (excp_valid),
    .excp_code_i      (excp_code),
    .ren              (ren_if.ctrl),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i),
    .out_pc_o         (out_pc_o),
    .out_excp_valid_o (out_excp_valid_o),
    .out_ecode_o      (out_ecode_o),
    .out_dest_valid_o (out_dest_valid_o),
    .out_psrc0_o      (out_psrc0_o),
    .out_psrc1_o      (out_psrc1_o),
    .out_pdest_o      (out_pdest_o),
    .out_ppdst_o      (out_ppdst_o)
  );

endmodule
